// File: hdl/s16_cfg.svh
`ifndef S16_CFG_SVH
`define S16_CFG_SVH

// Line on which the VBLANK interrupt is raised
`define S16_VBLANK_LINE 9'd223

// Value returned by unused I/O locations
`define S16_IO_IDLE 8'hff

// Value on the data bus when no device drives it
`define S16_BUS_IDLE 16'hffff

// ROM word-address width, bits 17 to 1
`define S16_ROM_AW 17

`endif

// File: hdl/s16_bus_pkg.sv
package s16_bus_pkg;

    typedef logic [23:1] cpu_addr_t;
    typedef logic [15:0] cpu_data_t;

    // Everything the 68000 drives onto its bus
    typedef struct packed {
        cpu_addr_t  addr;
        cpu_data_t  dout;   // write data, low byte also feeds the 8255
        logic       as_n;
        logic       uds_n;
        logic       lds_n;
        logic       rnw;
        logic [2:0] fc;
    } cpu_bus_t;

    // One bit per decoded region
    typedef struct packed {
        logic rom;
        logic vram;
        logic chr;
        logic obj;
        logic pal;
        logic io;
        logic wdog;
        logic ram;
    } mem_sel_t;

    typedef enum logic [1:0] {
        DTACK_IDLE,
        DTACK_WAIT,
        DTACK_ACK,
        DTACK_HOLD
    } dtack_state_t;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_ARMED,
        RAM_ACTIVE
    } ram_state_t;

endpackage

// File: hdl/s16_io_pkg.sv
package s16_io_pkg;

    typedef logic [7:0] joy_t;
    typedef logic [7:0] dip_t;
    typedef logic [7:0] ppi_port_t;

    // Cabinet controls, all active low
    typedef struct packed {
        joy_t       joystick1;
        joy_t       joystick2;
        logic [1:0] start_button;
        logic [1:0] coin_input;
        logic       service;
    } cab_in_t;

endpackage

// File: hdl/s16_mem_map.sv
`include "s16_cfg.svh"

module s16_mem_map (
    input  logic                   clk,
    input  logic                   rst,
    input  s16_bus_pkg::cpu_bus_t  bus,
    output s16_bus_pkg::mem_sel_t  sel,
    output logic                   berr_n,
    input  logic                   ram_cs,
    input  logic                   vram_cs,
    input  s16_bus_pkg::cpu_data_t rom_data,
    input  s16_bus_pkg::cpu_data_t ram_data,
    input  s16_bus_pkg::cpu_data_t char_dout,
    input  s16_bus_pkg::cpu_data_t pal_dout,
    input  s16_bus_pkg::cpu_data_t obj_dout,
    input  logic [7:0]             cab_dout,
    output s16_bus_pkg::cpu_data_t cpu_din
);
    import s16_bus_pkg::*;

    logic sel_valid;

    // System 16A map on the region byte A[23:16]
    function automatic mem_sel_t decode(input cpu_addr_t a);
        mem_sel_t s;
        s.rom  = a[23:22] == 2'd0 && !a[18];        // 00-03
        s.vram = a[22] && a[18:16] == 3'd0;         // 40
        s.chr  = a[22] && a[18:16] == 3'd1;         // 41
        s.obj  = a[23:22] == 2'd1 && a[18];         // 44
        s.pal  = a[23:22] == 2'd2 && a[18];         // 84
        s.io   = a[23:22] == 2'd3 && a[18:17] == 2'd2;  // c4
        s.wdog = a[23:22] == 2'd3 && a[18:16] == 3'd6;  // c6
        s.ram  = a[23:22] == 2'd3 && a[18:16] == 3'd7;  // c7
        return s;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel       <= '0;
            sel_valid <= 1'b0;
            berr_n    <= 1'b1;
        end else begin
            sel_valid <= !bus.as_n;
            if (!bus.as_n) begin
                sel <= decode(bus.addr);
            end else begin
                sel <= '0;
            end
            // Unmapped once the decode has settled and held to the end of the cycle
            if (bus.as_n) begin
                berr_n <= 1'b1;
            end else if (sel_valid && sel == '0) begin
                berr_n <= 1'b0;
            end
        end
    end

    // Read data with the RAM side already qualified by the strobe logic
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= `S16_BUS_IDLE;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (sel.rom) begin
            cpu_din <= rom_data;
        end else if (sel.chr) begin
            cpu_din <= char_dout;
        end else if (sel.pal) begin
            cpu_din <= pal_dout;
        end else if (sel.obj) begin
            cpu_din <= obj_dout;
        end else if (sel.io) begin
            cpu_din <= {`S16_IO_IDLE, cab_dout};
        end else begin
            cpu_din <= `S16_BUS_IDLE;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else $error("more than one region selected: %b", sel);

endmodule

// File: hdl/s16_ram_strobe.sv
module s16_ram_strobe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_cen,
    input  s16_bus_pkg::cpu_bus_t bus,
    input  logic                  pre_ram,
    input  logic                  pre_vram,
    output logic                  ram_cs,
    output logic                  vram_cs
);
    import s16_bus_pkg::*;

    logic       wr_strobe;
    logic [1:0] pre;
    logic [1:0] cs;

    // Write byte enables are valid
    assign wr_strobe = !bus.rnw && (!bus.uds_n || !bus.lds_n);
    assign pre       = {pre_ram, pre_vram};
    assign ram_cs    = cs[1];
    assign vram_cs   = cs[0];

    for (genvar i = 0; i < 2; i++) begin : g_chan
        ram_state_t state;
        logic       go;

        // Reads go at the next CPU enable while writes wait for a byte strobe
        assign go = cpu_cen && (bus.rnw || wr_strobe);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                state <= RAM_IDLE;
            end else begin
                case (state)
                    RAM_IDLE: begin
                        if (pre[i] && go) begin
                            state <= RAM_ACTIVE;
                        end else if (pre[i]) begin
                            state <= RAM_ARMED;
                        end
                    end
                    RAM_ARMED: begin
                        if (!pre[i]) begin
                            state <= RAM_IDLE;
                        end else if (go) begin
                            state <= RAM_ACTIVE;
                        end
                    end
                    RAM_ACTIVE: begin
                        if (!pre[i]) begin
                            state <= RAM_IDLE;
                        end
                    end
                    default: state <= RAM_IDLE;
                endcase
            end
        end

        // Drops together with the pre select
        assign cs[i] = state == RAM_ACTIVE && pre[i];
    end

    a_ram_cs_pre: assert property (@(posedge clk) disable iff (rst)
        $rose(ram_cs) |-> $past(pre_ram))
        else $error("ram_cs rose without a RAM select");

endmodule

// File: hdl/s16_dtack.sv
module s16_dtack (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_cen,
    input  logic                  cpu_cenb,
    input  logic                  as_n,
    input  s16_bus_pkg::mem_sel_t sel,
    input  logic                  rom_ok,
    input  logic                  ram_ok,
    output logic                  dtack_n
);
    import s16_bus_pkg::*;

    dtack_state_t state;
    logic         busy;
    logic         ready;

    // SDRAM backed regions stall until their data is there
    assign busy  = (sel.rom && !rom_ok) || ((sel.vram || sel.ram) && !ram_ok);
    assign ready = sel != '0 && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= DTACK_IDLE;
            dtack_n <= 1'b1;
        end else begin
            case (state)
                DTACK_IDLE: begin
                    if (!as_n && sel != '0) begin
                        if (ready && cpu_cenb) begin
                            state   <= DTACK_ACK;
                            dtack_n <= 1'b0;
                        end else begin
                            state <= DTACK_WAIT;
                        end
                    end
                end
                DTACK_WAIT: begin
                    if (as_n) begin
                        state <= DTACK_IDLE;
                    end else if (ready && cpu_cenb) begin
                        state   <= DTACK_ACK;
                        dtack_n <= 1'b0;
                    end
                end
                // Acknowledge stays until the CPU ends the cycle
                DTACK_ACK: begin
                    if (as_n) begin
                        state   <= DTACK_IDLE;
                        dtack_n <= 1'b1;
                    end else if (cpu_cen) begin
                        state <= DTACK_HOLD;
                    end
                end
                DTACK_HOLD: begin
                    if (as_n) begin
                        state   <= DTACK_IDLE;
                        dtack_n <= 1'b1;
                    end
                end
                default: begin
                    state   <= DTACK_IDLE;
                    dtack_n <= 1'b1;
                end
            endcase
        end
    end

    a_dtack_release: assert property (@(posedge clk) disable iff (rst) as_n |=> dtack_n)
        else $error("dtack_n still low after as_n went high");

endmodule

// File: hdl/s16_ppi.sv
`include "s16_cfg.svh"

module s16_ppi (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [1:0]            addr,
    input  s16_io_pkg::ppi_port_t din,
    input  logic                  wr,
    input  logic                  rd_cs,
    input  s16_io_pkg::ppi_port_t portc_din,
    output s16_io_pkg::ppi_port_t dout,
    output s16_io_pkg::ppi_port_t porta_dout,
    output s16_io_pkg::ppi_port_t portb_dout,
    output s16_io_pkg::ppi_port_t portc_dout
);
    import s16_io_pkg::*;

    ppi_port_t portc_rd;

    // Bit 6 of port C is an input on this board
    assign portc_rd = {portc_dout[7], portc_din[6], portc_dout[5:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            porta_dout <= `S16_IO_IDLE;
            portb_dout <= `S16_IO_IDLE;
            portc_dout <= `S16_IO_IDLE;
        end else if (wr) begin
            case (addr)
                2'd0: porta_dout <= din;
                2'd1: portb_dout <= din;
                2'd2: portc_dout <= din;
                2'd3: begin
                    // Bit set/reset, mode words are ignored
                    if (!din[7]) begin
                        portc_dout[din[3:1]] <= din[0];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dout = `S16_IO_IDLE;
        if (rd_cs) begin
            case (addr)
                2'd0: dout = porta_dout;
                2'd1: dout = portb_dout;
                2'd2: dout = portc_rd;
                default: dout = `S16_IO_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/s16_cabinet_io.sv
`include "s16_cfg.svh"

module s16_cabinet_io (
    input  logic                  clk,
    input  logic                  rst,
    input  s16_bus_pkg::cpu_bus_t bus,
    input  logic                  io_sel,
    input  s16_io_pkg::cab_in_t   cab,
    input  s16_io_pkg::dip_t      dipsw_a,
    input  s16_io_pkg::dip_t      dipsw_b,
    input  logic                  snd_ack,
    output logic [7:0]            cab_dout,
    output s16_io_pkg::ppi_port_t snd_latch,
    output logic                  snd_irq_n,
    output logic                  flip
);
    import s16_io_pkg::*;

    logic      ppi_cs;
    logic      ppi_wr;
    ppi_port_t ppi_dout;
    ppi_port_t portb;
    ppi_port_t portc;

    // Board wiring of the joystick bits
    function automatic joy_t sort_joy(input joy_t j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    assign ppi_cs    = io_sel && bus.addr[13:12] == 2'd0;
    assign ppi_wr    = ppi_cs && !bus.rnw && !bus.lds_n;
    assign snd_irq_n = portc[7];
    assign flip      = portb[7];

    s16_ppi u_ppi (
        .clk        (clk),
        .rst        (rst),
        .addr       (bus.addr[2:1]),
        .din        (bus.dout[7:0]),
        .wr         (ppi_wr),
        .rd_cs      (ppi_cs && bus.rnw),
        .portc_din  ({1'b1, snd_ack, 6'h3f}),
        .dout       (ppi_dout),
        .porta_dout (snd_latch),
        .portb_dout (portb),
        .portc_dout (portc)
    );

    always_comb begin
        cab_dout = `S16_IO_IDLE;
        if (io_sel) begin
            case (bus.addr[13:12])
                2'd0: cab_dout = ppi_dout;
                2'd1: begin
                    case (bus.addr[2:1])
                        2'd0: cab_dout = {2'b11, cab.start_button, cab.service, 1'b1,
                                          cab.coin_input};
                        2'd1: cab_dout = sort_joy(cab.joystick1);
                        2'd3: cab_dout = sort_joy(cab.joystick2);
                        default: cab_dout = `S16_IO_IDLE;
                    endcase
                end
                2'd2: cab_dout = bus.addr[1] ? dipsw_b : dipsw_a;
                default: cab_dout = `S16_IO_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/s16_vblank_irq.sv
`include "s16_cfg.svh"

module s16_vblank_irq (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [8:0]            vdump,
    input  logic                  hstart,
    input  s16_bus_pkg::cpu_bus_t bus,
    output logic                  irq_n
);
    logic last_hstart;
    logic int_ack;

    // CPU space cycle
    assign int_ack = &bus.fc && !bus.as_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hstart <= 1'b0;
            irq_n       <= 1'b1;
        end else begin
            last_hstart <= hstart;
            // Acknowledge wins over a request in the same clk
            if (int_ack) begin
                irq_n <= 1'b1;
            end else if (hstart && !last_hstart && vdump == `S16_VBLANK_LINE) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/s16_main.sv
`include "s16_cfg.svh"

module s16_main (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_cen,
    input  logic                      cpu_cenb,
    // CPU bus
    input  s16_bus_pkg::cpu_bus_t     bus,
    output s16_bus_pkg::cpu_data_t    cpu_din,
    output logic                      dtack_n,
    output logic                      berr_n,
    output logic                      irq_n,
    // Video timing
    input  logic [8:0]                vdump,
    input  logic                      hstart,
    // ROM
    output logic [`S16_ROM_AW:1]      rom_addr,
    output logic                      rom_cs,
    input  s16_bus_pkg::cpu_data_t    rom_data,
    input  logic                      rom_ok,
    // Work RAM and VRAM
    output logic                      ram_cs,
    output logic                      vram_cs,
    input  s16_bus_pkg::cpu_data_t    ram_data,
    input  logic                      ram_ok,
    // Video chips
    output logic                      char_cs,
    output logic                      pal_cs,
    output logic                      objram_cs,
    input  s16_bus_pkg::cpu_data_t    char_dout,
    input  s16_bus_pkg::cpu_data_t    pal_dout,
    input  s16_bus_pkg::cpu_data_t    obj_dout,
    // Cabinet
    input  s16_io_pkg::cab_in_t       cab,
    input  s16_io_pkg::dip_t          dipsw_a,
    input  s16_io_pkg::dip_t          dipsw_b,
    // Sound CPU link
    input  logic                      snd_ack,
    output s16_io_pkg::ppi_port_t     snd_latch,
    output logic                      snd_irq_n,
    output logic                      flip
);
    import s16_bus_pkg::*;

    mem_sel_t   sel;
    logic [7:0] cab_dout;

    assign rom_addr  = bus.addr[`S16_ROM_AW:1];
    assign rom_cs    = sel.rom;
    assign char_cs   = sel.chr;
    assign pal_cs    = sel.pal;
    assign objram_cs = sel.obj;

    s16_mem_map u_mem_map (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .sel       (sel),
        .berr_n    (berr_n),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

    s16_ram_strobe u_ram_strobe (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .bus      (bus),
        .pre_ram  (sel.ram),
        .pre_vram (sel.vram),
        .ram_cs   (ram_cs),
        .vram_cs  (vram_cs)
    );

    s16_dtack u_dtack (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .as_n     (bus.as_n),
        .sel      (sel),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .dtack_n  (dtack_n)
    );

    s16_cabinet_io u_cabinet_io (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .io_sel    (sel.io),
        .cab       (cab),
        .dipsw_a   (dipsw_a),
        .dipsw_b   (dipsw_b),
        .snd_ack   (snd_ack),
        .cab_dout  (cab_dout),
        .snd_latch (snd_latch),
        .snd_irq_n (snd_irq_n),
        .flip      (flip)
    );

    s16_vblank_irq u_vblank_irq (
        .clk    (clk),
        .rst    (rst),
        .vdump  (vdump),
        .hstart (hstart),
        .bus    (bus),
        .irq_n  (irq_n)
    );

endmodule

// File: tests/tb_s16_main.sv
`include "s16_cfg.svh"

module tb_s16_main;
    timeunit 1ns;
    timeprecision 1ps;

    import s16_bus_pkg::*;
    import s16_io_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int BUS_CYCLES     = 200;
    localparam int CLKS_PER_CYCLE = 40;
    // Source bit for joystick output bits 7 down to 0
    localparam int JOY_SRC [8] = '{1, 0, 3, 2, 7, 5, 4, 6};

    typedef enum logic [3:0] {
        R_NONE, R_ROM, R_VRAM, R_CHR, R_OBJ, R_PAL, R_IO, R_WDOG, R_RAM
    } region_t;

    logic             clk;
    logic             rst;
    logic             cpu_cen;
    logic             cpu_cenb;
    cpu_bus_t         bus;
    cpu_data_t        cpu_din;
    logic             dtack_n;
    logic             berr_n;
    logic             irq_n;
    logic [8:0]       vdump;
    logic             hstart;
    logic [`S16_ROM_AW:1] rom_addr;
    logic             rom_cs;
    cpu_data_t        rom_data;
    logic             rom_ok;
    logic             ram_cs;
    logic             vram_cs;
    cpu_data_t        ram_data;
    logic             ram_ok;
    logic             char_cs;
    logic             pal_cs;
    logic             objram_cs;
    cpu_data_t        char_dout;
    cpu_data_t        pal_dout;
    cpu_data_t        obj_dout;
    cab_in_t          cab;
    dip_t             dipsw_a;
    dip_t             dipsw_b;
    logic             snd_ack;
    ppi_port_t        snd_latch;
    logic             snd_irq_n;
    logic             flip;

    integer           seed = 32'hd069;
    logic [1:0]       cen_cnt;
    int               rom_wait;
    int               ram_wait;
    region_t          cur_region;
    cpu_data_t        exp_din;
    ppi_port_t        exp_latch;
    logic             exp_flip;
    logic             exp_snd_irq_n;
    logic             exp_irq_n;
    mem_sel_t         sel_seen;
    logic [7:0]       idle_flags;
    logic [23:0]      rnd_addr [8];

    s16_main s16_main_i (.*);

    // io and wdog have no select port of their own
    assign sel_seen   = {rom_cs, vram_cs, char_cs, objram_cs, pal_cs,
                         s16_main_i.sel.io, s16_main_i.sel.wdog, ram_cs};
    assign idle_flags = {dtack_n, berr_n, irq_n, snd_irq_n, flip, rom_cs, ram_cs, vram_cs};

    function automatic cpu_data_t model_word(input region_t r, input logic [23:0] baddr);
        return {r, baddr[12:1]};
    endfunction

    function automatic mem_sel_t region_bits(input region_t r);
        mem_sel_t s;
        s = '0;
        case (r)
            R_ROM:   s.rom  = 1'b1;
            R_VRAM:  s.vram = 1'b1;
            R_CHR:   s.chr  = 1'b1;
            R_OBJ:   s.obj  = 1'b1;
            R_PAL:   s.pal  = 1'b1;
            R_IO:    s.io   = 1'b1;
            R_WDOG:  s.wdog = 1'b1;
            R_RAM:   s.ram  = 1'b1;
            default: s = '0;
        endcase
        return s;
    endfunction

    function automatic joy_t joy_wired(input joy_t j);
        joy_t r;
        for (int i = 0; i < 8; i++) begin
            r[7 - i] = j[JOY_SRC[i]];
        end
        return r;
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_run();
    endtask

    // One 68000 bus cycle ended by dtack_n or berr_n
    task automatic run_cycle(input logic [23:0] baddr, input logic rnw, input cpu_data_t wdata,
                             input logic [2:0] fc, input region_t region);
        cur_region = region;
        @(posedge clk);
        bus.addr  <= baddr[23:1];
        bus.dout  <= wdata;
        bus.rnw   <= rnw;
        bus.fc    <= fc;
        bus.as_n  <= 1'b0;
        bus.uds_n <= !rnw;
        bus.lds_n <= !rnw;
        // Write strobes come late so the RAM select has to wait for them
        if (!rnw) begin
            repeat (8) @(posedge clk);
            bus.uds_n <= 1'b0;
            bus.lds_n <= 1'b0;
        end
        do begin
            @(posedge clk);
        end while (dtack_n && berr_n);
        bus.as_n  <= 1'b1;
        bus.uds_n <= 1'b1;
        bus.lds_n <= 1'b1;
        bus.rnw   <= 1'b1;
        bus.fc    <= 3'b000;
        repeat (3) @(posedge clk);
    endtask

    task automatic read_word(input logic [23:0] baddr, input region_t region,
                             input cpu_data_t expected);
        exp_din = expected;
        run_cycle(baddr, 1'b1, 16'h0000, 3'b101, region);
    endtask

    task automatic write_word(input logic [23:0] baddr, input region_t region,
                              input cpu_data_t data);
        run_cycle(baddr, 1'b0, data, 3'b101, region);
    endtask

    task automatic pulse_hstart(input logic [8:0] line);
        if (line == `S16_VBLANK_LINE) begin
            exp_irq_n = 1'b0;
        end
        @(posedge clk);
        vdump  <= line;
        hstart <= 1'b1;
        repeat (2) @(posedge clk);
        hstart <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // cpu_cenb two clks after cpu_cen
    always @(posedge clk) begin
        cen_cnt  <= cen_cnt + 2'd1;
        cpu_cen  <= cen_cnt == 2'd3;
        cpu_cenb <= cen_cnt == 2'd1;
    end

    // Board memories
    assign rom_data  = model_word(R_ROM, {6'd0, rom_addr, 1'b0});
    assign ram_data  = model_word(vram_cs ? R_VRAM : R_RAM, {bus.addr, 1'b0});
    assign char_dout = model_word(R_CHR, {bus.addr, 1'b0});
    assign pal_dout  = model_word(R_PAL, {bus.addr, 1'b0});
    assign obj_dout  = model_word(R_OBJ, {bus.addr, 1'b0});

    // SDRAM latency of 0 to 5 clks per access
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= $unsigned($random(seed)) % 6;
        end else if (rom_wait == 0) begin
            rom_ok <= 1'b1;
        end else begin
            rom_wait <= rom_wait - 1;
        end
        if (!(ram_cs || vram_cs)) begin
            ram_ok   <= 1'b0;
            ram_wait <= $unsigned($random(seed)) % 6;
        end else if (ram_wait == 0) begin
            ram_ok <= 1'b1;
        end else begin
            ram_wait <= ram_wait - 1;
        end
    end

    initial begin
        #(BUS_CYCLES * CLKS_PER_CYCLE * CLK_PERIOD);
        $display("Watchdog expired: the bus cycles did not finish in time");
        stop_run();
    end

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> idle_flags == 8'hf8)
        else report_mismatch("reset flags", 16'h00f8, $sampled(idle_flags));
    a_reset_din: assert property (@(posedge clk) $fell(rst) |-> cpu_din == `S16_BUS_IDLE)
        else report_mismatch("cpu_din", `S16_BUS_IDLE, $sampled(cpu_din));

    a_decode: assert property (@(posedge clk) disable iff (rst)
        !dtack_n && !bus.as_n |-> sel_seen == region_bits(cur_region))
        else report_mismatch("sel", region_bits(cur_region), $sampled(sel_seen));
    a_berr_mapped: assert property (@(posedge clk) disable iff (rst)
        !berr_n |-> cur_region == R_NONE)
        else report_problem("berr_n went low on a mapped address");
    a_berr_sel: assert property (@(posedge clk) disable iff (rst) !berr_n |-> sel_seen == '0)
        else report_mismatch("sel", 16'h0000, $sampled(sel_seen));
    a_unmapped_dtack: assert property (@(posedge clk) disable iff (rst)
        cur_region == R_NONE && !bus.as_n |-> dtack_n)
        else report_problem("dtack_n went low on an unmapped address");

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        !dtack_n && !bus.as_n && bus.rnw |-> cpu_din == exp_din)
        else report_mismatch("cpu_din", exp_din, $sampled(cpu_din));

    a_rom_wait: assert property (@(posedge clk) disable iff (rst) !dtack_n && rom_cs |-> rom_ok)
        else report_mismatch("rom_ok", 16'h0001, $sampled(rom_ok));
    a_ram_wait: assert property (@(posedge clk) disable iff (rst)
        !dtack_n && (ram_cs || vram_cs) |-> ram_ok)
        else report_mismatch("ram_ok", 16'h0001, $sampled(ram_ok));
    a_ram_strobe: assert property (@(posedge clk) disable iff (rst)
        (ram_cs || vram_cs) && !bus.as_n && !bus.rnw |-> !bus.uds_n || !bus.lds_n)
        else report_problem("RAM select active on a write before the byte strobes");

    // Port outputs are compared once each bus cycle has ended
    a_latch: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.as_n) |-> snd_latch == exp_latch)
        else report_mismatch("snd_latch", exp_latch, $sampled(snd_latch));
    a_flip: assert property (@(posedge clk) disable iff (rst) $rose(bus.as_n) |-> flip == exp_flip)
        else report_mismatch("flip", exp_flip, $sampled(flip));
    a_snd_irq: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.as_n) |-> snd_irq_n == exp_snd_irq_n)
        else report_mismatch("snd_irq_n", exp_snd_irq_n, $sampled(snd_irq_n));
    a_irq: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.as_n) || $fell(hstart) |-> irq_n == exp_irq_n)
        else report_mismatch("irq_n", exp_irq_n, $sampled(irq_n));

    initial begin
        logic [31:0] rnd;
        rst           = 1'b1;
        cen_cnt       = 2'd0;
        cpu_cen       = 1'b0;
        cpu_cenb      = 1'b0;
        bus           = '0;
        bus.as_n      = 1'b1;
        bus.uds_n     = 1'b1;
        bus.lds_n     = 1'b1;
        bus.rnw       = 1'b1;
        vdump         = 9'd0;
        hstart        = 1'b0;
        rom_ok        = 1'b0;
        ram_ok        = 1'b0;
        rom_wait      = 0;
        ram_wait      = 0;
        snd_ack       = 1'b0;
        cur_region    = R_NONE;
        exp_din       = `S16_BUS_IDLE;
        exp_latch     = 8'hff;
        exp_flip      = 1'b1;
        exp_snd_irq_n = 1'b1;
        exp_irq_n     = 1'b1;
        rnd           = $random(seed);
        cab           = rnd[20:0];
        rnd           = $random(seed);
        dipsw_a       = rnd[7:0];
        dipsw_b       = rnd[15:8];
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            rnd_addr[i] = i[0] ? {8'hc7, rnd[15:1], 1'b0} : {6'd0, rnd[17:1], 1'b0};
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        // One read to each region
        read_word(24'h012344, R_ROM, model_word(R_ROM, 24'h012344));
        read_word(24'h400abc, R_VRAM, model_word(R_VRAM, 24'h400abc));
        read_word(24'h410246, R_CHR, model_word(R_CHR, 24'h410246));
        read_word(24'h440108, R_OBJ, model_word(R_OBJ, 24'h440108));
        read_word(24'h840a0e, R_PAL, model_word(R_PAL, 24'h840a0e));
        read_word(24'hc70ff0, R_RAM, model_word(R_RAM, 24'hc70ff0));
        read_word(24'hc60000, R_WDOG, `S16_BUS_IDLE);
        read_word(24'hc43000, R_IO, {`S16_IO_IDLE, `S16_IO_IDLE});

        // Unmapped
        read_word(24'h040000, R_NONE, `S16_BUS_IDLE);
        read_word(24'h420000, R_NONE, `S16_BUS_IDLE);
        read_word(24'hc20000, R_NONE, `S16_BUS_IDLE);

        // Writes where the RAM selects wait for the late strobes
        write_word(24'h400100, R_VRAM, 16'h1234);
        write_word(24'hc70200, R_RAM, 16'h5678);
        write_word(24'h410040, R_CHR, 16'h0f0f);
        write_word(24'h440020, R_OBJ, 16'ha5a5);
        write_word(24'h840010, R_PAL, 16'h7e7e);
        write_word(24'hc60000, R_WDOG, 16'h0000);

        // Back-pressure with random addresses
        for (int i = 0; i < 8; i++) begin
            read_word(rnd_addr[i], i[0] ? R_RAM : R_ROM,
                      model_word(i[0] ? R_RAM : R_ROM, rnd_addr[i]));
        end

        // Cabinet inputs and DIP switches
        read_word(24'hc41000, R_IO, {`S16_IO_IDLE, 2'b11, cab.start_button, cab.service, 1'b1,
                                     cab.coin_input});
        read_word(24'hc41002, R_IO, {`S16_IO_IDLE, joy_wired(cab.joystick1)});
        read_word(24'hc41006, R_IO, {`S16_IO_IDLE, joy_wired(cab.joystick2)});
        read_word(24'hc41004, R_IO, {`S16_IO_IDLE, `S16_IO_IDLE});
        read_word(24'hc42000, R_IO, {`S16_IO_IDLE, dipsw_a});
        read_word(24'hc42002, R_IO, {`S16_IO_IDLE, dipsw_b});

        // Peripheral ports
        exp_latch = 8'h5a;
        write_word(24'hc40000, R_IO, 16'h005a);
        exp_flip = 1'b0;
        write_word(24'hc40002, R_IO, 16'h0000);
        exp_flip = 1'b1;
        write_word(24'hc40002, R_IO, 16'h0080);
        // Port C bit 7 cleared then set again
        exp_snd_irq_n = 1'b0;
        write_word(24'hc40006, R_IO, 16'h000e);
        read_word(24'hc40004, R_IO, {`S16_IO_IDLE, 1'b0, 1'b0, 6'h3f});
        @(posedge clk);
        snd_ack <= 1'b1;
        read_word(24'hc40004, R_IO, {`S16_IO_IDLE, 1'b0, 1'b1, 6'h3f});
        exp_snd_irq_n = 1'b1;
        write_word(24'hc40006, R_IO, 16'h000f);
        read_word(24'hc40004, R_IO, {`S16_IO_IDLE, 1'b1, 1'b1, 6'h3f});

        // VBLANK interrupt
        pulse_hstart(9'd100);
        pulse_hstart(9'd222);
        pulse_hstart(`S16_VBLANK_LINE);
        pulse_hstart(9'd224);
        exp_irq_n = 1'b1;
        exp_din   = model_word(R_RAM, 24'hfffff8);
        run_cycle(24'hfffff8, 1'b1, 16'h0000, 3'b111, R_RAM);
        pulse_hstart(9'd10);

        repeat (10) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/s16_bus_pkg.sv
hdl/s16_io_pkg.sv
hdl/s16_mem_map.sv
hdl/s16_ram_strobe.sv
hdl/s16_dtack.sv
hdl/s16_ppi.sv
hdl/s16_cabinet_io.sv
hdl/s16_vblank_irq.sv
hdl/s16_main.sv
tests/tb_s16_main.sv
